/* common/rx_pkg.sv */
// one weight set and one shift serve all channels; register map assumes word-aligned accesses
package rx_pkg;

    // data path geometry
    localparam int num_channels = 2;
    localparam int ffe_length   = 4;
    localparam int code_width   = 8;
    localparam int weight_width = 10;
    localparam int shift_width  = 4;
    localparam int result_width = 8;

    // product of one code and one weight, before accumulation
    localparam int prod_width = code_width + weight_width;
    // full sum of ffe_length products cannot overflow this
    localparam int acc_width  = 20;

    // previous words kept on the capture side
    localparam int hist_words = 2;
    localparam int word_width = num_channels * code_width;
    localparam int hist_width = hist_words * word_width;
    // symbols seen by the FFE for one word, oldest first
    localparam int win_len    = num_channels + ffe_length - 1;

    // saturation limits of the signed result
    localparam int res_max = (2 ** (result_width - 1)) - 1;
    localparam int res_min = -(2 ** (result_width - 1));

    // AXI4-Lite configuration port
    localparam int axi_addr_width = 6;
    localparam int axi_data_width = 32;

    // register map, tap k lives at reg_weight_base + 4k
    localparam logic [axi_addr_width-1:0] reg_shift_addr  = 6'h00;
    localparam logic [axi_addr_width-1:0] reg_weight_base = 6'h04;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

endpackage

/* hw/rx_code_capture.sv */
// history only advances on valid words; window is oldest symbol first, code 0 of a word earliest
module rx_code_capture
    import rx_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [word_width-1:0]          codes_i,
    input  logic                           code_valid_i,
    output logic [win_len*code_width-1:0]  window_o,
    output logic                           win_valid_o
);

    // newest captured word and the words before it
    logic [word_width-1:0] word_q;
    logic [hist_width-1:0] hist_q;
    logic                  valid_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            word_q  <= '0;
            hist_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= code_valid_i;
            if (code_valid_i) begin
                word_q <= codes_i;
                // oldest word drops out at the low end
                hist_q <= {word_q, hist_q[hist_width-1:word_width]};
            end
        end
    end

    // newest word on top of the most recent ffe_length-1 older symbols
    assign window_o    = {word_q, hist_q[hist_width-1 -: (ffe_length-1)*code_width]};
    assign win_valid_o = valid_q;

endmodule

/* ffe/ffe_core.sv */
// two-cycle latency; weights sampled in stage 1, shift in stage 2, so reconfigure only when idle
module ffe_core
    import rx_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [win_len*code_width-1:0]      window_i,
    input  logic                               win_valid_i,
    input  logic [ffe_length*weight_width-1:0] weights_i,
    input  logic [shift_width-1:0]             shift_i,
    output logic [num_channels*result_width-1:0] result_o,
    output logic                               res_valid_o
);

    logic signed [code_width-1:0]   sym_c [win_len];
    logic signed [weight_width-1:0] tap_c [ffe_length];

    logic signed [prod_width-1:0]   prod_q [num_channels][ffe_length];
    logic                           valid1_q;

    logic signed [acc_width-1:0]    acc_c [num_channels];
    logic signed [acc_width-1:0]    shr_c [num_channels];
    logic signed [result_width-1:0] sat_c [num_channels];

    // unpack the flat buses
    always_comb begin
        for (int i = 0; i < win_len; i++) begin
            sym_c[i] = window_i[i*code_width +: code_width];
        end
        for (int k = 0; k < ffe_length; k++) begin
            tap_c[k] = weights_i[k*weight_width +: weight_width];
        end
    end

    // stage 1: tap k times the symbol k places before symbol j
    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            for (int j = 0; j < num_channels; j++) begin
                for (int k = 0; k < ffe_length; k++) begin
                    prod_q[j][k] <= sym_c[ffe_length-1+j-k] * tap_c[k];
                end
            end
        end
    end

    // stage 2 combinational part: sum, arithmetic shift, clamp
    always_comb begin
        for (int j = 0; j < num_channels; j++) begin
            acc_c[j] = '0;
            for (int k = 0; k < ffe_length; k++) begin
                acc_c[j] = acc_c[j] + prod_q[j][k];
            end
            shr_c[j] = acc_c[j] >>> shift_i;
            if (shr_c[j] > res_max) begin
                sat_c[j] = result_width'(res_max);
            end else if (shr_c[j] < res_min) begin
                sat_c[j] = result_width'(res_min);
            end else begin
                sat_c[j] = shr_c[j][result_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid1_q) begin
            for (int j = 0; j < num_channels; j++) begin
                result_o[j*result_width +: result_width] <= sat_c[j];
            end
        end
    end

    // valid follows both stages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid1_q    <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            valid1_q    <= win_valid_i;
            res_valid_o <= valid1_q;
        end
    end

endmodule

/* hw/rx_slicer.sv */
// zero slices to 0; data bits hold their last value while data_valid_o is low
module rx_slicer
    import rx_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic [num_channels*result_width-1:0] result_i,
    input  logic                                 res_valid_i,
    output logic [num_channels-1:0]              data_o,
    output logic                                 data_valid_o
);

    logic signed [result_width-1:0] sample_c [num_channels];
    logic [num_channels-1:0]        bit_c;

    // strictly positive sample gives a one
    always_comb begin
        for (int j = 0; j < num_channels; j++) begin
            sample_c[j] = result_i[j*result_width +: result_width];
            bit_c[j]    = (sample_c[j] > 0);
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            data_o <= bit_c;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= res_valid_i;
        end
    end

endmodule

/* hw/rx_config_regs.sv */
// one outstanding transaction per direction; exact address match only, WSTRB treated as all-or-nothing
module rx_config_regs
    import rx_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [axi_addr_width-1:0]          s_awaddr_i,
    input  logic                               s_awvalid_i,
    output logic                               s_awready_o,
    input  logic [axi_data_width-1:0]          s_wdata_i,
    input  logic [axi_data_width/8-1:0]        s_wstrb_i,
    input  logic                               s_wvalid_i,
    output logic                               s_wready_o,
    output logic [1:0]                         s_bresp_o,
    output logic                               s_bvalid_o,
    input  logic                               s_bready_i,
    input  logic [axi_addr_width-1:0]          s_araddr_i,
    input  logic                               s_arvalid_i,
    output logic                               s_arready_o,
    output logic [axi_data_width-1:0]          s_rdata_o,
    output logic [1:0]                         s_rresp_o,
    output logic                               s_rvalid_o,
    input  logic                               s_rready_i,
    output logic [ffe_length*weight_width-1:0] weights_o,
    output logic [shift_width-1:0]             shift_o
);

    logic signed [weight_width-1:0] weight_q [ffe_length];
    logic [shift_width-1:0]         shift_q;

    logic                           bvalid_q;
    axi_resp_e                      bresp_q;
    logic                           rvalid_q;
    axi_resp_e                      rresp_q;
    logic [axi_data_width-1:0]      rdata_q;

    logic                           wr_hs;
    logic                           rd_hs;
    logic                           wr_hit_shift;
    logic                           rd_hit_shift;
    logic [ffe_length-1:0]          wr_hit_w;
    logic [ffe_length-1:0]          rd_hit_w;
    logic [axi_data_width-1:0]      rd_data_c;

    // address and data taken together, blocked while a response waits
    assign s_awready_o = s_awvalid_i & s_wvalid_i & ~bvalid_q;
    assign s_wready_o  = s_awready_o;
    assign s_arready_o = s_arvalid_i & ~rvalid_q;
    assign wr_hs       = s_awready_o;
    assign rd_hs       = s_arready_o;

    // address decode
    assign wr_hit_shift = (s_awaddr_i == reg_shift_addr);
    assign rd_hit_shift = (s_araddr_i == reg_shift_addr);
    always_comb begin
        for (int k = 0; k < ffe_length; k++) begin
            wr_hit_w[k] = (s_awaddr_i == reg_weight_base + axi_addr_width'(4 * k));
            rd_hit_w[k] = (s_araddr_i == reg_weight_base + axi_addr_width'(4 * k));
        end
    end

    // weights read back sign extended, shift zero extended, holes as zero
    always_comb begin
        rd_data_c = '0;
        if (rd_hit_shift) begin
            rd_data_c = {{(axi_data_width-shift_width){1'b0}}, shift_q};
        end
        for (int k = 0; k < ffe_length; k++) begin
            if (rd_hit_w[k]) begin
                rd_data_c = {{(axi_data_width-weight_width){weight_q[k][weight_width-1]}},
                             weight_q[k]};
            end
        end
    end

    // register file
    always_ff @(posedge clk) begin
        if (rst_i) begin
            shift_q <= '0;
            for (int k = 0; k < ffe_length; k++) begin
                weight_q[k] <= '0;
            end
        end else if (wr_hs && (|s_wstrb_i)) begin
            if (wr_hit_shift) begin
                shift_q <= s_wdata_i[shift_width-1:0];
            end
            for (int k = 0; k < ffe_length; k++) begin
                if (wr_hit_w[k]) begin
                    weight_q[k] <= s_wdata_i[weight_width-1:0];
                end
            end
        end
    end

    // write response channel
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bvalid_q <= 1'b0;
            bresp_q  <= resp_okay;
        end else if (wr_hs) begin
            bvalid_q <= 1'b1;
            bresp_q  <= (wr_hit_shift || (|wr_hit_w)) ? resp_okay : resp_slverr;
        end else if (s_bready_i) begin
            bvalid_q <= 1'b0;
        end
    end

    // read data channel
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_hs) begin
            rvalid_q <= 1'b1;
        end else if (s_rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_data_c;
            rresp_q <= (rd_hit_shift || (|rd_hit_w)) ? resp_okay : resp_slverr;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = bresp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rresp_o  = rresp_q;
    assign s_rdata_o  = rdata_q;

    always_comb begin
        for (int k = 0; k < ffe_length; k++) begin
            weights_o[k*weight_width +: weight_width] = weight_q[k];
        end
    end
    assign shift_o = shift_q;

endmodule

/* hw/rx_top.sv */
// code to data latency is 4 cycles with no back-pressure; reconfigure only while the stream is idle
module rx_top
    import rx_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [word_width-1:0]       codes_i,
    input  logic                        code_valid_i,
    output logic [num_channels-1:0]     data_o,
    output logic                        data_valid_o,
    input  logic [axi_addr_width-1:0]   s_awaddr_i,
    input  logic                        s_awvalid_i,
    output logic                        s_awready_o,
    input  logic [axi_data_width-1:0]   s_wdata_i,
    input  logic [axi_data_width/8-1:0] s_wstrb_i,
    input  logic                        s_wvalid_i,
    output logic                        s_wready_o,
    output logic [1:0]                  s_bresp_o,
    output logic                        s_bvalid_o,
    input  logic                        s_bready_i,
    input  logic [axi_addr_width-1:0]   s_araddr_i,
    input  logic                        s_arvalid_i,
    output logic                        s_arready_o,
    output logic [axi_data_width-1:0]   s_rdata_o,
    output logic [1:0]                  s_rresp_o,
    output logic                        s_rvalid_o,
    input  logic                        s_rready_i
);

    logic [win_len*code_width-1:0]        window;
    logic                                 win_valid;
    logic [ffe_length*weight_width-1:0]   weights;
    logic [shift_width-1:0]               shift;
    logic [num_channels*result_width-1:0] result;
    logic                                 res_valid;

    rx_code_capture i_capture (
        .clk          (clk),
        .rst_i        (rst_i),
        .codes_i      (codes_i),
        .code_valid_i (code_valid_i),
        .window_o     (window),
        .win_valid_o  (win_valid)
    );

    ffe_core i_ffe (
        .clk         (clk),
        .rst_i       (rst_i),
        .window_i    (window),
        .win_valid_i (win_valid),
        .weights_i   (weights),
        .shift_i     (shift),
        .result_o    (result),
        .res_valid_o (res_valid)
    );

    rx_slicer i_slicer (
        .clk          (clk),
        .rst_i        (rst_i),
        .result_i     (result),
        .res_valid_i  (res_valid),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

    rx_config_regs i_config (
        .clk         (clk),
        .rst_i       (rst_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .weights_o   (weights),
        .shift_o     (shift)
    );

endmodule

/* testbench/tb_rx_model.svh */
// reference model of the receiver; valid only while the stream is idle during reconfiguration
`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

// register file copy
logic signed [weight_width-1:0] m_weight [ffe_length];
logic [shift_width-1:0]         m_shift;
// earlier symbols, index 0 is the most recent one
logic signed [code_width-1:0]   m_prev [ffe_length-1];
// expected bit words in arrival order
logic [num_channels-1:0]        exp_q [$];

function automatic void model_reset();
    m_shift = '0;
    for (int k = 0; k < ffe_length; k++) begin
        m_weight[k] = '0;
    end
    for (int i = 0; i < ffe_length - 1; i++) begin
        m_prev[i] = '0;
    end
endfunction

function automatic logic [1:0] model_write(input logic [axi_addr_width-1:0] addr,
                                           input logic [axi_data_width-1:0] data);
    if (addr == reg_shift_addr) begin
        m_shift = data[shift_width-1:0];
        return resp_okay;
    end
    for (int k = 0; k < ffe_length; k++) begin
        if (addr == weight_addr(k)) begin
            m_weight[k] = data[weight_width-1:0];
            return resp_okay;
        end
    end
    return resp_slverr;
endfunction

function automatic logic [1:0] model_read(input logic [axi_addr_width-1:0] addr,
                                          output logic [axi_data_width-1:0] data);
    data = '0;
    if (addr == reg_shift_addr) begin
        data[shift_width-1:0] = m_shift;
        return resp_okay;
    end
    for (int k = 0; k < ffe_length; k++) begin
        if (addr == weight_addr(k)) begin
            // weights come back sign extended
            data = axi_data_width'(longint'(m_weight[k]));
            return resp_okay;
        end
    end
    return resp_slverr;
endfunction

// filter, shift, clamp and slice one word, then advance the history
function automatic void model_push(input logic [word_width-1:0] codes);
    logic signed [code_width-1:0] cur [num_channels];
    logic signed [code_width-1:0] sym;
    longint                       sum;
    longint                       top;
    logic [num_channels-1:0]      bits;
    top = (longint'(1) << (result_width - 1)) - 1;
    for (int j = 0; j < num_channels; j++) begin
        cur[j] = codes[j*code_width +: code_width];
    end
    for (int j = 0; j < num_channels; j++) begin
        sum = 0;
        for (int k = 0; k < ffe_length; k++) begin
            sym = (k <= j) ? cur[j-k] : m_prev[k-j-1];
            sum = sum + longint'(sym) * longint'(m_weight[k]);
        end
        sum = sum >>> m_shift;
        if (sum > top) sum = top;
        if (sum < -top - 1) sum = -top - 1;
        bits[j] = (sum > 0);
    end
    exp_q.push_back(bits);
    for (int j = 0; j < num_channels; j++) begin
        for (int i = ffe_length - 2; i > 0; i--) begin
            m_prev[i] = m_prev[i-1];
        end
        m_prev[0] = cur[j];
    end
endfunction

`endif

/* testbench/tb_rx.sv */
// drives the receiver with LFSR stimulus; reconfigures only after the stream has drained
module tb_rx
    import rx_pkg::*;
;

    // budget of config transactions for reset reads, register test and four configurations
    localparam int cfg_ops       = 5 + 18 + 4 * 5;
    localparam int stream_cycles = 20 + 60 + 60 + 30;
    localparam int cycle_limit   = cfg_ops * 12 + stream_cycles + 4 * 10 + 200;

    logic                        clk;
    logic                        rst_i;
    logic [word_width-1:0]       codes_i;
    logic                        code_valid_i;
    logic [num_channels-1:0]     data_o;
    logic                        data_valid_o;
    logic [axi_addr_width-1:0]   s_awaddr_i;
    logic                        s_awvalid_i;
    logic                        s_awready_o;
    logic [axi_data_width-1:0]   s_wdata_i;
    logic [axi_data_width/8-1:0] s_wstrb_i;
    logic                        s_wvalid_i;
    logic                        s_wready_o;
    logic [1:0]                  s_bresp_o;
    logic                        s_bvalid_o;
    logic                        s_bready_i;
    logic [axi_addr_width-1:0]   s_araddr_i;
    logic                        s_arvalid_i;
    logic                        s_arready_o;
    logic [axi_data_width-1:0]   s_rdata_o;
    logic [1:0]                  s_rresp_o;
    logic                        s_rvalid_o;
    logic                        s_rready_i;

    logic [31:0]                 lfsr_state = 32'h631b;
    logic [3:0]                  valid_pipe = '0;
    logic [num_channels-1:0]     expected;
    int                          cycle_count;
    int                          data_errors = 0;
    int                          reg_errors = 0;
    int                          proto_errors = 0;

    rx_top i_dut (.*);

    function automatic logic [axi_addr_width-1:0] weight_addr(input int k);
        return reg_weight_base + axi_addr_width'(4 * k);
    endfunction

    `include "tb_rx_model.svh"

    // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] extreme_weight();
        return rand_bits(1) ? 32'd511 : 32'hffff_fe00;
    endfunction

    task automatic print_counts();
        $display("errors: data %0d, register %0d, protocol %0d",
                 data_errors, reg_errors, proto_errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        proto_errors++;
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("Verification failed");
        $finish;
    end

    // outputs sampled at the falling edge
    always @(negedge clk) begin
        if (!rst_i) begin
            assert (data_valid_o == valid_pipe[3]) else begin
                proto_errors++;
                $display("ERROR %0t: data_valid_o is %0b, expected %0b",
                         $time, data_valid_o, valid_pipe[3]);
            end
            if (data_valid_o && exp_q.size() == 0) begin
                proto_errors++;
                $display("data_valid_o went high with no word expected at %0t", $time);
            end else if (data_valid_o) begin
                expected = exp_q.pop_front();
                assert (data_o === expected) else begin
                    data_errors++;
                    $display("ERROR %0t: data_o is %b, expected %b", $time, data_o, expected);
                end
            end
        end
        valid_pipe = {valid_pipe[2:0], code_valid_i};
    end

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic axi_write(input logic [axi_addr_width-1:0] addr,
                             input logic [axi_data_width-1:0] data, output logic [1:0] resp);
        logic got;
        int   stall;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_wstrb_i   = '1;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        do begin
            @(negedge clk);
            got = s_awready_o;
            // address and data are taken in the same cycle
            assert (s_wready_o === s_awready_o) else begin
                proto_errors++;
                $display("ERROR %0t: s_wready_o is %0b while s_awready_o is %0b",
                         $time, s_wready_o, s_awready_o);
            end
            step_cycle();
        end while (!got);
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        // hold BREADY back a few cycles
        stall = rand_bits(2);
        repeat (stall) step_cycle();
        s_bready_i = 1'b1;
        do begin
            @(negedge clk);
            got  = s_bvalid_o;
            resp = s_bresp_o;
            step_cycle();
        end while (!got);
        s_bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [axi_addr_width-1:0] addr,
                            output logic [axi_data_width-1:0] data, output logic [1:0] resp);
        logic got;
        int   stall;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        do begin
            @(negedge clk);
            got = s_arready_o;
            step_cycle();
        end while (!got);
        s_arvalid_i = 1'b0;
        stall = rand_bits(2);
        repeat (stall) step_cycle();
        s_rready_i = 1'b1;
        do begin
            @(negedge clk);
            got  = s_rvalid_o;
            data = s_rdata_o;
            resp = s_rresp_o;
            step_cycle();
        end while (!got);
        s_rready_i = 1'b0;
    endtask

    task automatic check_write(input logic [axi_addr_width-1:0] addr,
                               input logic [axi_data_width-1:0] data);
        logic [1:0] resp;
        logic [1:0] exp_resp;
        exp_resp = model_write(addr, data);
        axi_write(addr, data, resp);
        assert (resp == exp_resp) else begin
            reg_errors++;
            $display("ERROR %0t: write to 0x%02h gave resp %0d, expected %0d",
                     $time, addr, resp, exp_resp);
        end
    endtask

    task automatic check_read(input logic [axi_addr_width-1:0] addr);
        logic [axi_data_width-1:0] data;
        logic [axi_data_width-1:0] exp_data;
        logic [1:0]                resp;
        logic [1:0]                exp_resp;
        exp_resp = model_read(addr, exp_data);
        axi_read(addr, data, resp);
        assert (resp == exp_resp && data == exp_data) else begin
            reg_errors++;
            $display("ERROR %0t: read of 0x%02h gave 0x%08h resp %0d, expected 0x%08h resp %0d",
                     $time, addr, data, resp, exp_data, exp_resp);
        end
    endtask

    task automatic check_all_regs();
        check_read(reg_shift_addr);
        for (int k = 0; k < ffe_length; k++) begin
            check_read(weight_addr(k));
        end
    endtask

    task automatic configure(input logic [31:0] w0, input logic [31:0] w1,
                             input logic [31:0] w2, input logic [31:0] w3,
                             input logic [31:0] shift);
        check_write(weight_addr(0), w0);
        check_write(weight_addr(1), w1);
        check_write(weight_addr(2), w2);
        check_write(weight_addr(3), w3);
        check_write(reg_shift_addr, shift);
    endtask

    // gap_bits 0 keeps every cycle valid
    // otherwise one value in 2**gap_bits is a gap
    task automatic run_stream(input int ncycles, input int gap_bits, input bit extreme);
        logic [word_width-1:0] codes;
        for (int c = 0; c < ncycles; c++) begin
            for (int j = 0; j < num_channels; j++) begin
                if (extreme) begin
                    codes[j*code_width +: code_width] = rand_bits(1) ? 8'h7f : 8'h80;
                end else begin
                    codes[j*code_width +: code_width] = rand_bits(code_width);
                end
            end
            codes_i      = codes;
            code_valid_i = (gap_bits == 0) ? 1'b1 : (rand_bits(gap_bits) != 0);
            if (code_valid_i) begin
                model_push(codes);
            end
            step_cycle();
        end
        code_valid_i = 1'b0;
        // drain the pipeline before anything is reconfigured
        while (exp_q.size() != 0) step_cycle();
        repeat (2) step_cycle();
    endtask

    initial begin
        rst_i        = 1'b1;
        codes_i      = '0;
        code_valid_i = 1'b0;
        s_awaddr_i   = '0;
        s_awvalid_i  = 1'b0;
        s_wdata_i    = '0;
        s_wstrb_i    = '0;
        s_wvalid_i   = 1'b0;
        s_bready_i   = 1'b0;
        s_araddr_i   = '0;
        s_arvalid_i  = 1'b0;
        s_rready_i   = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        #10;
        rst_i = 1'b0;

        // reset state
        @(negedge clk);
        assert (!data_valid_o && !s_bvalid_o && !s_rvalid_o) else begin
            proto_errors++;
            $display("ERROR %0t: valid outputs not low after reset", $time);
        end
        step_cycle();
        check_all_regs();

        // register access and unmapped writes that must change nothing
        for (int k = 0; k < ffe_length; k++) begin
            check_write(weight_addr(k), rand_bits(32));
        end
        check_write(reg_shift_addr, rand_bits(32));
        check_all_regs();
        check_write(6'h14, rand_bits(32));
        check_write(6'h02, rand_bits(32));
        check_all_regs();
        check_read(6'h3c);

        // identity equalizer
        configure(32'd1, 32'd0, 32'd0, 32'd0, 32'd0);
        run_stream(20, 0, 1'b0);

        // random equalization with valid most cycles
        configure(rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
        run_stream(60, 3, 1'b0);

        // frequent gaps in the stream
        configure(rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
        run_stream(60, 1, 1'b0);

        // sums far beyond the result range
        configure(extreme_weight(), extreme_weight(), extreme_weight(), extreme_weight(), 32'd0);
        run_stream(30, 0, 1'b1);

        print_counts();
        if (data_errors + reg_errors + proto_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+testbench
common/rx_pkg.sv
hw/rx_code_capture.sv
ffe/ffe_core.sv
hw/rx_slicer.sv
hw/rx_config_regs.sv
hw/rx_top.sv
testbench/tb_rx.sv

/* run_sim.sh */
#!/bin/sh
# builds tb_rx with Verilator, runs it and looks for the pass message in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_rx -o tb_rx_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
exit 1
